//--- include/replay_defines.svh
////////////////////////////////////////////////////////////////////////////
// valid replayer sizing, with widths, channel count, buffer depths
// and the width of the happen-before difference counters
////////////////////////////////////////////////////////////////////////////
`ifndef REPLAY_DEFINES_SVH
`define REPLAY_DEFINES_SVH

// data beat carried with logb
`define RPL_DATA_WIDTH 16
// log-end channels summed over all recorded interfaces
`define RPL_LOGE_CHANNEL_CNT 4

// slots in the replay skid buffer
`define RPL_FIFO_DEPTH 2
// register stages the almost-full passes on its way upstream
`define RPL_PIPE_DEPTH 2

// worst runtime vs replay gap seen on one channel
// the extra 3 covers the decoder merge tree and its output queue
`define RPL_ON_THE_FLY_CNT (`RPL_FIFO_DEPTH + `RPL_PIPE_DEPTH + 3)

// wrapping two's complement counter
// any two counts closer than half the circle compare correctly,
// so twice the gap is enough range
`define RPL_PKT_CNT_WIDTH $clog2(2 * `RPL_ON_THE_FLY_CNT)

`endif

//--- hdl/replay_trace_pkg.sv
////////////////////////////////////////////////////////////////////////////
// trace side types for the valid replayer
////////////////////////////////////////////////////////////////////////////
`default_nettype none

`include "replay_defines.svh"

package replay_trace_pkg;

  // one logb beat as recorded
  typedef logic [`RPL_DATA_WIDTH-1:0] data_t;

  // log-end events, one bit per channel
  typedef logic [`RPL_LOGE_CHANNEL_CNT-1:0] loge_mask_t;

  // skid buffer occupancy
  //   EMPTY  nothing held
  //   BUSY   head slot holds an entry
  //   FULL   head and spare slot both hold entries
  // the encoding 2'b11 is never reached
  typedef enum logic [1:0] {
    EMPTY = 2'd0,
    BUSY  = 2'd1,
    FULL  = 2'd2
  } buf_state_e;

endpackage : replay_trace_pkg

`default_nettype wire

//--- hdl/happen_before_pkg.sv
////////////////////////////////////////////////////////////////////////////
// counter side types for happen-before enforcement
////////////////////////////////////////////////////////////////////////////
`default_nettype none

`include "replay_defines.svh"

package happen_before_pkg;

  // runtime count minus replay count, wraps modulo 2**width
  typedef logic [`RPL_PKT_CNT_WIDTH-1:0] pkt_diff_t;

  // one difference per log-end channel
  typedef pkt_diff_t pkt_diff_arr_t [`RPL_LOGE_CHANNEL_CNT];

  // msb of a difference, set means runtime is still behind
  localparam int unsigned PKT_SIGN_BIT = `RPL_PKT_CNT_WIDTH - 1;

  // collected sign bits, one per channel
  typedef logic [`RPL_LOGE_CHANNEL_CNT-1:0] diff_sign_t;

endpackage : happen_before_pkg

`default_nettype wire

//--- hdl/replay_skid_buffer.sv
////////////////////////////////////////////////////////////////////////////
// two slot skid buffer for replay trace entries, keeps the head slot
// and reports when it loads so the counters can follow
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module replay_skid_buffer (
  input  logic                         clk,
  input  logic                         rstn,
  // trace entries
  input  logic                         i_in_valid,
  input  logic                         i_logb_valid,
  input  replay_trace_pkg::data_t      i_logb_data,
  input  replay_trace_pkg::loge_mask_t i_loge_valid,
  output logic                         o_in_ready,
  // output handshake, watched to know when the head is consumed
  input  logic                         i_out_ready,
  input  logic                         i_out_valid,
  // head slot toward the gate and the downstream port
  output replay_trace_pkg::data_t      o_head_data,
  output logic                         o_head_load,
  output replay_trace_pkg::loge_mask_t o_head_loge,
  output logic                         o_head_logb_next,
  output logic                         o_head_busy_next
);
  import replay_trace_pkg::*;

  buf_state_e state_q;
  buf_state_e state_next;

  // handshake events
  logic insert;
  logic pop_logb;
  logic pop_loge;
  logic pop;
  logic fill;

  // head slot, data flag is kept apart since the gate needs it early
  logic       head_logb_q;
  logic       head_from_spare;
  logic       head_logb_in;
  data_t      head_data_in;

  // spare slot, only meaningful while FULL
  logic       spare_logb_q;
  data_t      spare_data_q;
  loge_mask_t spare_loge_q;

  ////////////////////////////////////////////////////////////////////////////
  // handshake events
  ////////////////////////////////////////////////////////////////////////////

  assign insert = i_in_valid && o_in_ready;

  // data beat taken downstream
  assign pop_logb = i_out_valid && i_out_ready;
  // head without data only carries log-ends, gone after one cycle
  assign pop_loge = (state_q != EMPTY) && !head_logb_q;
  assign pop = pop_logb || pop_loge;

  ////////////////////////////////////////////////////////////////////////////
  // occupancy FSM
  ////////////////////////////////////////////////////////////////////////////

  // EMPTY -> BUSY on load
  // BUSY  -> FULL on fill (insert, no pop)
  // BUSY  -> BUSY on flow (insert and pop) or idle
  // BUSY  -> EMPTY on unload (pop, no insert)
  // FULL  -> BUSY on flush, spare moves into head
  always_comb begin
    state_next = state_q;
    case (state_q)
      EMPTY: begin
        if (insert) begin
          state_next = BUSY;
        end
      end
      BUSY: begin
        if (insert && !pop) begin
          state_next = FULL;
        end else if (!insert && pop) begin
          state_next = EMPTY;
        end
      end
      FULL: begin
        // in_ready is low here, so no insert can race the flush
        if (!insert && pop) begin
          state_next = BUSY;
        end
      end
      default: begin
        state_next = EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q <= EMPTY;
    end else begin
      state_q <= state_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // slot movement
  ////////////////////////////////////////////////////////////////////////////

  // second entry arrives while the head is still waiting
  assign fill = (state_q == BUSY) && (state_next == FULL);

  // head reloads on load, flow and flush
  assign o_head_load = (state_next == BUSY) && ((state_q == FULL) || insert);

  // flush takes the spare, load and flow take the input
  assign head_from_spare = (state_q == FULL);
  assign head_logb_in    = head_from_spare ? spare_logb_q : i_logb_valid;
  assign head_data_in    = head_from_spare ? spare_data_q : i_logb_data;
  assign o_head_loge     = head_from_spare ? spare_loge_q : i_loge_valid;

  always_ff @(posedge clk) begin
    if (fill) begin
      spare_logb_q <= i_logb_valid;
      spare_data_q <= i_logb_data;
      spare_loge_q <= i_loge_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (o_head_load) begin
      o_head_data <= head_data_in;
    end
  end

  // data flag of the head as it will be next cycle
  // stale in EMPTY, but busy_next masks it there
  assign o_head_logb_next = o_head_load ? head_logb_in : head_logb_q;
  assign o_head_busy_next = (state_next != EMPTY);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      head_logb_q <= 1'b0;
    end else begin
      head_logb_q <= o_head_logb_next;
    end
  end

  // registered ready, low for the whole FULL stay
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_in_ready <= 1'b0;
    end else begin
      o_in_ready <= (state_next != FULL);
    end
  end

endmodule : replay_skid_buffer

`default_nettype wire

//--- hdl/happen_before_gate.sv
////////////////////////////////////////////////////////////////////////////
// happen-before gate, per channel runtime minus replay counters that
// decide the registered output valid
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "replay_defines.svh"

module happen_before_gate (
  input  logic                         clk,
  input  logic                         rstn,
  // runtime log-end pulses, no back-pressure
  input  replay_trace_pkg::loge_mask_t i_rt_loge_valid,
  // head slot events from the skid buffer
  input  logic                         i_head_load,
  input  replay_trace_pkg::loge_mask_t i_head_loge,
  input  logic                         i_head_logb_next,
  input  logic                         i_head_busy_next,
  // registered valid toward the output port
  output logic                         o_out_valid
);
  import happen_before_pkg::*;

  // diff_q holds runtime minus replay up to this cycle
  // diff_next adds this cycle's runtime pulses and the head being loaded
  pkt_diff_arr_t diff_q;
  pkt_diff_arr_t diff_next;
  diff_sign_t    sign_next;
  logic          ok_to_replay;

  ////////////////////////////////////////////////////////////////////////////
  // difference counters
  ////////////////////////////////////////////////////////////////////////////

  // the replay count includes the entry entering the head, because the
  // log-ends of an entry were packed with its own data beat at record time
  //
  // the counters wrap freely, only the sign bit is read
  // stimulus keeps every gap inside the on-the-fly bound, which is what
  // keeps the sign honest
  always_comb begin
    for (int c = 0; c < `RPL_LOGE_CHANNEL_CNT; c++) begin
      diff_next[c] = diff_q[c] + pkt_diff_t'(i_rt_loge_valid[c]);
      if (i_head_load) begin
        diff_next[c] = diff_next[c] - pkt_diff_t'(i_head_loge[c]);
      end
      // set when runtime is still behind the replay
      sign_next[c] = diff_next[c][PKT_SIGN_BIT];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int c = 0; c < `RPL_LOGE_CHANNEL_CNT; c++) begin
        diff_q[c] <= '0;
      end
    end else begin
      for (int c = 0; c < `RPL_LOGE_CHANNEL_CNT; c++) begin
        diff_q[c] <= diff_next[c];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output valid
  ////////////////////////////////////////////////////////////////////////////

  // every channel has caught up, so the head may go out
  assign ok_to_replay = ~|sign_next;

  // looking one cycle ahead lets out_valid come straight from a flop
  // once high it stays high under back-pressure,
  // runtime counts only grow while the head is held
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_out_valid <= 1'b0;
    end else begin
      o_out_valid <= i_head_busy_next && i_head_logb_next && ok_to_replay;
    end
  end

endmodule : happen_before_gate

`default_nettype wire

//--- hdl/valid_replayer.sv
////////////////////////////////////////////////////////////////////////////
// valid replayer top, skid buffer followed by the happen-before gate
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module valid_replayer (
  input  logic                         clk,
  input  logic                         rstn,
  // replay trace entries
  input  logic                         i_in_valid,
  input  logic                         i_logb_valid,
  input  replay_trace_pkg::data_t      i_logb_data,
  input  replay_trace_pkg::loge_mask_t i_loge_valid,
  output logic                         o_in_ready,
  // runtime log-end pulses
  input  replay_trace_pkg::loge_mask_t i_rt_loge_valid,
  // replayed data toward the design
  output logic                         o_out_valid,
  input  logic                         i_out_ready,
  output replay_trace_pkg::data_t      o_out_data
);
  import replay_trace_pkg::*;

  // head slot events between the stages
  logic       head_load;
  loge_mask_t head_loge;
  logic       head_logb_next;
  logic       head_busy_next;

  // entry storage and head bookkeeping
  // out_valid from the gate feeds back here to pop the head
  replay_skid_buffer skid_buffer_i (
    .clk              (clk),
    .rstn             (rstn),
    .i_in_valid       (i_in_valid),
    .i_logb_valid     (i_logb_valid),
    .i_logb_data      (i_logb_data),
    .i_loge_valid     (i_loge_valid),
    .o_in_ready       (o_in_ready),
    .i_out_ready      (i_out_ready),
    .i_out_valid      (o_out_valid),
    .o_head_data      (o_out_data),
    .o_head_load      (head_load),
    .o_head_loge      (head_loge),
    .o_head_logb_next (head_logb_next),
    .o_head_busy_next (head_busy_next)
  );

  // per channel ordering check against runtime
  happen_before_gate hb_gate_i (
    .clk              (clk),
    .rstn             (rstn),
    .i_rt_loge_valid  (i_rt_loge_valid),
    .i_head_load      (head_load),
    .i_head_loge      (head_loge),
    .i_head_logb_next (head_logb_next),
    .i_head_busy_next (head_busy_next),
    .o_out_valid      (o_out_valid)
  );

endmodule : valid_replayer

`default_nettype wire

//--- verif/valid_replayer_tb.sv
////////////////////////////////////////////////////////////////////////////
// valid replayer testbench, replays the golden trace and checks order,
// happen-before and back-pressure on the output handshake
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "replay_defines.svh"

module valid_replayer_tb;
  import replay_trace_pkg::*;

  // golden image layout, 24-bit words
  localparam int GOLDEN_DEPTH = 256;
  localparam int ENTRY_BASE   = 'h10;
  localparam int SCHED_BASE   = 'h40;
  localparam int EXPECT_BASE  = 'h80;
  localparam int MAX_ENTRIES  = SCHED_BASE - ENTRY_BASE;
  localparam int MAX_SCHED    = EXPECT_BASE - SCHED_BASE;
  localparam int MAX_EXPECT   = GOLDEN_DEPTH - EXPECT_BASE;
  localparam int CH_CNT       = `RPL_LOGE_CHANNEL_CNT;
  // quiet cycles after the last beat, catches stray transfers
  localparam int DRAIN_CYCLES = 8;

  logic       clk;
  logic       rstn;
  logic       i_in_valid;
  logic       i_logb_valid;
  data_t      i_logb_data;
  loge_mask_t i_loge_valid;
  logic       o_in_ready;
  loge_mask_t i_rt_loge_valid;
  logic       o_out_valid;
  logic       i_out_ready;
  data_t      o_out_data;

  // raw image and the three views split out of it
  logic [23:0] golden_mem [GOLDEN_DEPTH];
  logic        entry_logb [MAX_ENTRIES];
  data_t       entry_data [MAX_ENTRIES];
  loge_mask_t  entry_loge [MAX_ENTRIES];
  loge_mask_t  sched_mask [MAX_SCHED];
  data_t       expect_data [MAX_EXPECT];
  // replay count per channel through the k-th data entry, itself included
  int          need_cnt [MAX_EXPECT][CH_CNT];
  int          n_entries;
  int          n_sched;
  int          n_expect;
  int          n_data;

  // reference counts, runtime pulses driven and entry masks accepted
  int          rt_cnt [CH_CNT];
  int          replay_cnt [CH_CNT];

  int          seed;
  int          errors;
  int          cycle;
  int          transfers;
  int          entry_idx;
  int          drain;
  int          timeout_limit;
  bit          file_ok;
  bit          timed_out;
  bit          entry_taken;
  bit          hold_pending;
  data_t       hold_data;

  valid_replayer dut_i (
    .clk             (clk),
    .rstn            (rstn),
    .i_in_valid      (i_in_valid),
    .i_logb_valid    (i_logb_valid),
    .i_logb_data     (i_logb_data),
    .i_loge_valid    (i_loge_valid),
    .o_in_ready      (o_in_ready),
    .i_rt_loge_valid (i_rt_loge_valid),
    .o_out_valid     (o_out_valid),
    .i_out_ready     (i_out_ready),
    .o_out_data      (o_out_data)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // golden data
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_golden();
    int k;
    int cum [CH_CNT];
    $readmemh("verif/valid_replayer_golden.txt", golden_mem);
    file_ok = 1'b0;
    if ($isunknown(golden_mem[0]) || $isunknown(golden_mem[1]) ||
        $isunknown(golden_mem[2])) begin
      $display("ERROR: golden file could not be read or has no count words");
      errors++;
    end else begin
      n_entries = golden_mem[0];
      n_sched   = golden_mem[1];
      n_expect  = golden_mem[2];
      if (n_entries < 1 || n_entries > MAX_ENTRIES || n_sched > MAX_SCHED ||
          n_expect > MAX_EXPECT) begin
        $display("ERROR: golden file counts do not fit the image layout");
        errors++;
      end else begin
        k = 0;
        for (int c = 0; c < CH_CNT; c++) begin
          cum[c] = 0;
        end
        for (int i = 0; i < n_entries; i++) begin
          entry_logb[i] = golden_mem[ENTRY_BASE + i][20];
          entry_data[i] = golden_mem[ENTRY_BASE + i][19:4];
          entry_loge[i] = golden_mem[ENTRY_BASE + i][3:0];
          // an entry's own log-ends count before its data may go out
          for (int c = 0; c < CH_CNT; c++) begin
            cum[c] += entry_loge[i][c];
          end
          if (entry_logb[i]) begin
            for (int c = 0; c < CH_CNT; c++) begin
              need_cnt[k][c] = cum[c];
            end
            k++;
          end
        end
        n_data = k;
        for (int i = 0; i < n_sched; i++) begin
          sched_mask[i] = golden_mem[SCHED_BASE + i][3:0];
        end
        for (int i = 0; i < n_expect; i++) begin
          expect_data[i] = golden_mem[EXPECT_BASE + i][15:0];
        end
        if (n_data != n_expect) begin
          $display("ERROR: golden file lists %0d expected beats but %0d data entries",
                   n_expect, n_data);
          errors++;
        end else begin
          file_ok = 1'b1;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // drivers and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_idle_outputs(input string phase);
    if (o_in_ready !== 1'b0) begin
      $display("MISMATCH at %0t: o_in_ready is %b %s, expected 0", $time, o_in_ready, phase);
      errors++;
    end
    if (o_out_valid !== 1'b0) begin
      $display("MISMATCH at %0t: o_out_valid is %b %s, expected 0", $time, o_out_valid, phase);
      errors++;
    end
  endtask

  // called 1 ns after the rising edge
  task automatic drive_inputs();
    // runtime side follows the schedule, then goes quiet
    if (cycle < n_sched) begin
      i_rt_loge_valid = sched_mask[cycle];
    end else begin
      i_rt_loge_valid = '0;
    end
    // downstream mostly ready
    i_out_ready = (($random(seed) & 3) != 0);
    // source holds an entry until it is taken
    if (!i_in_valid || entry_taken) begin
      i_in_valid   = 1'b0;
      i_logb_valid = 1'b0;
      i_logb_data  = '0;
      i_loge_valid = '0;
      // an idle cycle now and then between entries
      if (entry_idx < n_entries && ($random(seed) & 7) != 0) begin
        i_in_valid   = 1'b1;
        i_logb_valid = entry_logb[entry_idx];
        i_logb_data  = entry_data[entry_idx];
        i_loge_valid = entry_loge[entry_idx];
      end
    end
    entry_taken = 1'b0;
  endtask

  // called at the falling edge, everything stable for the coming edge
  task automatic sample_outputs();
    int gap;
    for (int c = 0; c < CH_CNT; c++) begin
      rt_cnt[c] += i_rt_loge_valid[c];
    end
    // stalled beat from last cycle must still be there
    if (hold_pending) begin
      if (o_out_valid !== 1'b1) begin
        $display("MISMATCH at %0t: o_out_valid dropped under back-pressure", $time);
        errors++;
      end else if (o_out_data !== hold_data) begin
        $display("MISMATCH at %0t: o_out_data changed under back-pressure, %h then %h",
                 $time, hold_data, o_out_data);
        errors++;
      end
    end
    hold_pending = 1'b0;
    if (o_out_valid === 1'b1 && i_out_ready) begin
      if (transfers >= n_data) begin
        $display("ERROR at %0t: extra output beat %h after all %0d expected beats",
                 $time, o_out_data, n_data);
        errors++;
      end else begin
        if (o_out_data !== expect_data[transfers]) begin
          $display("MISMATCH at %0t: beat %0d data %h, expected %h",
                   $time, transfers, o_out_data, expect_data[transfers]);
          errors++;
        end
        for (int c = 0; c < CH_CNT; c++) begin
          if (rt_cnt[c] < need_cnt[transfers][c]) begin
            $display("MISMATCH at %0t: beat %0d out early, ch%0d runtime %0d of %0d",
                     $time, transfers, c, rt_cnt[c], need_cnt[transfers][c]);
            errors++;
          end
        end
      end
      transfers++;
    end else if (o_out_valid === 1'b1) begin
      hold_pending = 1'b1;
      hold_data    = o_out_data;
    end else if (o_out_valid !== 1'b0) begin
      $display("MISMATCH at %0t: o_out_valid is unknown", $time);
      errors++;
    end
    // trace side acceptance
    if (i_in_valid && o_in_ready === 1'b1) begin
      for (int c = 0; c < CH_CNT; c++) begin
        replay_cnt[c] += entry_loge[entry_idx][c];
      end
      entry_idx++;
      entry_taken = 1'b1;
    end
    // counters in the DUT only stay correct inside this window
    for (int c = 0; c < CH_CNT; c++) begin
      gap = rt_cnt[c] - replay_cnt[c];
      if (gap > `RPL_ON_THE_FLY_CNT || -gap > `RPL_ON_THE_FLY_CNT) begin
        $display("ERROR at %0t: stimulus gap on ch%0d is %0d, beyond the bound", $time, c, gap);
        errors++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk             = 1'b0;
    rstn            = 1'b0;
    i_in_valid      = 1'b0;
    i_logb_valid    = 1'b0;
    i_logb_data     = '0;
    i_loge_valid    = '0;
    i_rt_loge_valid = '0;
    i_out_ready     = 1'b0;
    seed            = 40;
    errors          = 0;
    cycle           = 0;
    transfers       = 0;
    entry_idx       = 0;
    drain           = 0;
    timed_out       = 1'b0;
    entry_taken     = 1'b0;
    hold_pending    = 1'b0;
    hold_data       = '0;
    n_entries       = 0;
    n_sched         = 0;
    n_expect        = 0;
    n_data          = 0;
    for (int c = 0; c < CH_CNT; c++) begin
      rt_cnt[c]     = 0;
      replay_cnt[c] = 0;
    end
    load_golden();
    timeout_limit = 20 * n_entries + n_sched;

    // five edges in reset
    repeat (4) begin
      @(negedge clk);
      check_idle_outputs("during reset");
    end
    @(posedge clk);
    #1;
    rstn = 1'b1;
    @(negedge clk);
    check_idle_outputs("in the first cycle after reset");

    if (file_ok) begin
      while (drain < DRAIN_CYCLES && !timed_out) begin
        @(posedge clk);
        #1;
        drive_inputs();
        @(negedge clk);
        sample_outputs();
        cycle++;
        if (entry_idx == n_entries && transfers >= n_data) begin
          drain++;
        end else if (cycle >= timeout_limit) begin
          timed_out = 1'b1;
          $display("TIMEOUT at %0t: output stalled, %0d of %0d beats and %0d of %0d entries",
                   $time, transfers, n_data, entry_idx, n_entries);
          errors++;
        end
      end
      if (!timed_out && transfers != n_data) begin
        $display("ERROR: %0d output beats seen, the golden trace holds %0d data entries",
                 transfers, n_data);
        errors++;
      end
    end

    $display("errors %0d, beats %0d of %0d, cycles %0d", errors, transfers, n_data, cycle);
    if (errors == 0 && !timed_out) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : valid_replayer_tb

`default_nettype wire

//--- files.f
+incdir+include
hdl/replay_trace_pkg.sv
hdl/happen_before_pkg.sv
hdl/replay_skid_buffer.sv
hdl/happen_before_gate.sv
hdl/valid_replayer.sv
verif/valid_replayer_tb.sv

//--- verif/valid_replayer_golden.txt
// valid replayer golden image for $readmemh, one 24-bit hex word per value
// entry words hold logb flag (1 digit), data (4 digits), loge mask (1 digit)
@00
// entry count, schedule length in cycles, expected beat count
14 30 0f
@10
// trace entries in replay order
13c510
107e21
0dead2  // no data, ch1 log-end only
1b4132
15a5a0
1c0de4
0bad09  // no data, ch0 and ch3
011118  // no data, ch3
180010
10ff00
1d2e73
144110
0ffff4  // no data, ch2
19abcc
16e050
1f00d1
05555f  // no data, every channel
12b7a0
1e3c92
17f100
@40
// runtime pulse mask per cycle, bit n is channel n
0 0 0 0 1 0 0 2
0 0 0 2 0 0 4 0
0 8 0 1 0 0 8 0
0 0 3 0 0 0 4 0
0 c 0 0 0 1 0 0
0 f 0 0 0 2 0 0
@80
// expected output data in transfer order
3c51 07e2 b413 5a5a c0de 8001 0ff0 d2e7
4411 9abc 6e05 f00d 2b7a e3c9 7f10
